/* Bender.yml */
package:
  name: fighter_frame

sources:
  - include_dirs:
      - hw
    files:
      - hw/fighter_pkg.sv
      - hw/sprite_pkg.sv
      - hw/pose_decode.sv
      - hw/anim_sequencer.sv
      - hw/sheet_addresser.sv
      - hw/descriptor_queue.sv
      - hw/fighter_frame_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verification/fighter_frame_tb.sv

/* hw/anim_sequencer.sv */
/*
 * Animation sequencer stage
 * Per-fighter tick counters that walk through the cels of the
 * current pose and restart on a pose change
 */
`timescale 1ns/1ns
`include "fighter_defs.svh"

module anim_sequencer (
    input  logic                             vsync,
    input  logic                             reset,
    input  logic                             stall,
    input  fighter_pkg::fighter_pose_t [1:0] poses,
    output fighter_pkg::anim_state_t [1:0]   anim
);
    import fighter_pkg::*;

    logic [`TICK_W-1:0] tick      [2];
    logic [`TICK_W-1:0] tick_next [2];

    // Last tick of one full animation loop
    function automatic logic [`TICK_W-1:0] last_tick(pose_t p);
        int unsigned cels;
        case (p)
            POSE_STAND:   cels = 6;
            POSE_FORWARD: cels = 4;
            POSE_BACK:    cels = 4;
            POSE_KICK:    cels = 5;
            POSE_PUNCH:   cels = 4;
            POSE_SQUAT:   cels = 1;
            default:      cels = 1;
        endcase
        return `TICK_W'(cels * `TICKS_PER_CEL - 1);
    endfunction

    // --------------------------------------------------
    // Tick update
    // --------------------------------------------------
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (poses[i].changed)
                tick_next[i] = '0;                    // New pose starts at its first cel
            else if (tick[i] >= last_tick(poses[i].pose))
                tick_next[i] = '0;
            else
                tick_next[i] = tick[i] + 1'b1;
        end
    end

    always_ff @(posedge vsync or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2; i++) begin
                tick[i] <= '0;
                anim[i] <= '{pose: POSE_STAND, cel: '0};
            end
        end else if (!stall) begin                   // Frozen while the output is full
            for (int i = 0; i < 2; i++) begin
                tick[i]      <= tick_next[i];
                anim[i].pose <= poses[i].pose;
                anim[i].cel  <= `CEL_W'(tick_next[i] / `TICKS_PER_CEL);
            end
        end
    end

endmodule

/* hw/descriptor_queue.sv */
/*
 * Descriptor queue
 * Small FIFO between the frame pipeline and the renderer, sends
 * one frame per available renderer credit
 */
`timescale 1ns/1ns
`include "fighter_defs.svh"

module descriptor_queue (
    input  logic                      vsync,
    input  logic                      reset,
    input  sprite_pkg::sprite_frame_t frame,
    output logic                      stall,
    output logic                      frame_valid,
    output sprite_pkg::sprite_frame_t frame_out,
    input  logic                      credit_return
);
    import sprite_pkg::*;

    localparam int PTR_W = (`QUEUE_DEPTH > 1) ? $clog2(`QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);
    localparam int CRD_W = $clog2(`CREDIT_MAX + 1);

    sprite_frame_t    mem [`QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] credits;
    logic             push;
    logic             send;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
        return (p == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign stall = (count == CNT_W'(`QUEUE_DEPTH));
    assign push  = !stall;                          // Stage three holds its result while full
    assign send  = (count != '0) && (credits != '0);

    always_ff @(posedge vsync) begin
        if (push)
            mem[wr_ptr] <= frame;
        if (send)
            frame_out <= mem[rd_ptr];
    end

    always_ff @(posedge vsync or posedge reset) begin
        if (reset) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            credits     <= CRD_W'(`CREDIT_MAX);
            frame_valid <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (send)
                rd_ptr <= next_ptr(rd_ptr);
            count       <= count + CNT_W'(push) - CNT_W'(send);
            credits     <= credits + CRD_W'(credit_return) - CRD_W'(send);
            frame_valid <= send;
        end
    end

endmodule

/* hw/fighter_defs.svh */
/*
 * Fighter frame pipeline parameters
 * Field widths, animation rate, output queue sizing and the
 * sprite sheet dimensions of both fighters
 */
`ifndef FIGHTER_DEFS_SVH
`define FIGHTER_DEFS_SVH

`define TICK_W          6
`define CEL_W           3
`define ADDR_W          18
`define DIM_W           10
`define TICKS_PER_CEL   7
`define QUEUE_DEPTH     2
`define CREDIT_MAX      2     // Renderer line buffers

`define STAND_H         112   // Reference height, offsets are taken against it

// --------------------------------------------------
// Fighter one sheets
// --------------------------------------------------
`define F0_STAND_W      80
`define F0_STAND_H      112
`define F0_FORWARD_W    96
`define F0_FORWARD_H    112
`define F0_BACK_W       80
`define F0_BACK_H       112
`define F0_KICK_W       102
`define F0_KICK_H       112
`define F0_PUNCH_W      128
`define F0_PUNCH_H      96
`define F0_SQUAT_W      80
`define F0_SQUAT_H      64

// --------------------------------------------------
// Fighter two sheets
// --------------------------------------------------
`define F1_STAND_W      80
`define F1_STAND_H      112
`define F1_FORWARD_W    80
`define F1_FORWARD_H    128
`define F1_BACK_W       80
`define F1_BACK_H       128
`define F1_KICK_W       112
`define F1_KICK_H       128
`define F1_PUNCH_W      96
`define F1_PUNCH_H      112
`define F1_SQUAT_W      64
`define F1_SQUAT_H      80

`endif

/* hw/fighter_frame_top.sv */
/*
 * Fighter frame top
 * Pose decode, animation, sheet addressing and the renderer queue
 */
`timescale 1ns/1ns

module fighter_frame_top (
    input  logic                           vsync,
    input  logic                           reset,
    input  fighter_pkg::action_req_t [1:0] actions,
    input  logic                           stop,
    input  logic                           credit_return,
    output logic                           frame_valid,
    output sprite_pkg::sprite_frame_t      frame_out
);
    import fighter_pkg::*;
    import sprite_pkg::*;

    logic                stall;   // Queue full, whole pipeline holds
    fighter_pose_t [1:0] poses;
    anim_state_t   [1:0] anim;
    sprite_frame_t       frame;

    pose_decode u_pose_decode (
        .vsync   (vsync),
        .reset   (reset),
        .stall   (stall),
        .actions (actions),
        .stop    (stop),
        .poses   (poses)
    );

    anim_sequencer u_anim_sequencer (
        .vsync (vsync),
        .reset (reset),
        .stall (stall),
        .poses (poses),
        .anim  (anim)
    );

    sheet_addresser u_sheet_addresser (
        .vsync (vsync),
        .reset (reset),
        .stall (stall),
        .anim  (anim),
        .frame (frame)
    );

    descriptor_queue u_descriptor_queue (
        .vsync         (vsync),
        .reset         (reset),
        .frame         (frame),
        .stall         (stall),
        .frame_valid   (frame_valid),
        .frame_out     (frame_out),
        .credit_return (credit_return)
    );

endmodule

/* hw/fighter_pkg.sv */
/*
 * Fighter state types
 * Button requests, the chosen pose and the animation state
 * carried between the first two pipeline stages
 */
`include "fighter_defs.svh"

package fighter_pkg;

    // One bit per action button
    typedef struct packed {
        logic forward;
        logic back;
        logic punch;
        logic squat;
        logic kick;
        logic jump;
    } action_req_t;

    typedef enum logic [2:0] {
        POSE_STAND   = 3'd0,
        POSE_FORWARD = 3'd1,
        POSE_BACK    = 3'd2,
        POSE_KICK    = 3'd3,
        POSE_PUNCH   = 3'd4,
        POSE_SQUAT   = 3'd5
    } pose_t;

    typedef struct packed {
        pose_t pose;
        logic  changed;   // Pose differs from the previous frame
    } fighter_pose_t;

    typedef struct packed {
        pose_t              pose;
        logic [`CEL_W-1:0]  cel;
    } anim_state_t;

endpackage

/* hw/pose_decode.sv */
/*
 * Pose decode stage
 * Picks one pose per fighter from its buttons and flags pose changes
 */
`timescale 1ns/1ns

module pose_decode (
    input  logic                            vsync,
    input  logic                            reset,
    input  logic                            stall,
    input  fighter_pkg::action_req_t [1:0]  actions,
    input  logic                            stop,
    output fighter_pkg::fighter_pose_t [1:0] poses
);
    import fighter_pkg::*;

    pose_t next_pose [2];

    // Priority forward, back, kick, punch, squat; jump has no sheet
    function automatic pose_t pick_pose(action_req_t a, logic halt);
        if (halt)
            return POSE_STAND;
        else if (a.forward)
            return POSE_FORWARD;
        else if (a.back)
            return POSE_BACK;
        else if (a.kick)
            return POSE_KICK;
        else if (a.punch)
            return POSE_PUNCH;
        else if (a.squat)
            return POSE_SQUAT;
        else
            return POSE_STAND;
    endfunction

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            next_pose[i] = pick_pose(actions[i], stop);
        end
    end

    always_ff @(posedge vsync or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2; i++) begin
                poses[i] <= '{pose: POSE_STAND, changed: 1'b0};
            end
        end else if (!stall) begin
            for (int i = 0; i < 2; i++) begin
                poses[i].pose    <= next_pose[i];
                poses[i].changed <= (next_pose[i] != poses[i].pose);
            end
        end
    end

endmodule

/* hw/sheet_addresser.sv */
/*
 * Sheet addresser stage
 * Looks up cel geometry per fighter and pose, then builds the
 * descriptor with ROM base address and vertical offset
 */
`timescale 1ns/1ns
`include "fighter_defs.svh"

module sheet_addresser (
    input  logic                           vsync,
    input  logic                           reset,
    input  logic                           stall,
    input  fighter_pkg::anim_state_t [1:0] anim,
    output sprite_pkg::sprite_frame_t      frame
);
    import fighter_pkg::*;
    import sprite_pkg::*;

    localparam logic signed [`DIM_W:0] STAND_Y = `STAND_H;

    function automatic sheet_dim_t sheet_dims(logic fighter, pose_t p);
        sheet_dim_t d;
        if (!fighter) begin
            case (p)
                POSE_FORWARD: d = '{`F0_FORWARD_W, `F0_FORWARD_H};
                POSE_BACK:    d = '{`F0_BACK_W, `F0_BACK_H};
                POSE_KICK:    d = '{`F0_KICK_W, `F0_KICK_H};
                POSE_PUNCH:   d = '{`F0_PUNCH_W, `F0_PUNCH_H};
                POSE_SQUAT:   d = '{`F0_SQUAT_W, `F0_SQUAT_H};
                default:      d = '{`F0_STAND_W, `F0_STAND_H};
            endcase
        end else begin
            case (p)
                POSE_FORWARD: d = '{`F1_FORWARD_W, `F1_FORWARD_H};
                POSE_BACK:    d = '{`F1_BACK_W, `F1_BACK_H};
                POSE_KICK:    d = '{`F1_KICK_W, `F1_KICK_H};
                POSE_PUNCH:   d = '{`F1_PUNCH_W, `F1_PUNCH_H};
                POSE_SQUAT:   d = '{`F1_SQUAT_W, `F1_SQUAT_H};
                default:      d = '{`F1_STAND_W, `F1_STAND_H};
            endcase
        end
        return d;
    endfunction

    function automatic sprite_desc_t make_desc(logic fighter, pose_t p,
                                               logic [`CEL_W-1:0] cel);
        sheet_dim_t   d;
        sprite_desc_t s;
        d           = sheet_dims(fighter, p);
        s.pose      = p;
        s.cel       = cel;
        s.width     = d.width;
        s.height    = d.height;
        s.y_offset  = (STAND_Y - $signed({1'b0, d.height})) <<< 1;   // Sheets are drawn 2x
        s.base_addr = `ADDR_W'(cel) * `ADDR_W'(d.width) * `ADDR_W'(d.height);
        return s;
    endfunction

    always_ff @(posedge vsync or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2; i++) begin
                frame[i] <= make_desc(i == 1, POSE_STAND, '0);
            end
        end else if (!stall) begin
            for (int i = 0; i < 2; i++) begin
                frame[i] <= make_desc(i == 1, anim[i].pose, anim[i].cel);
            end
        end
    end

endmodule

/* hw/sprite_pkg.sv */
/*
 * Sprite sheet types
 * Cel geometry and the per-frame descriptor sent to the renderer
 */
`include "fighter_defs.svh"

package sprite_pkg;

    typedef struct packed {
        logic [`DIM_W-1:0] width;
        logic [`DIM_W-1:0] height;
    } sheet_dim_t;

    typedef struct packed {
        fighter_pkg::pose_t       pose;
        logic [`CEL_W-1:0]        cel;
        logic [`DIM_W-1:0]        width;
        logic [`DIM_W-1:0]        height;
        logic signed [`DIM_W:0]   y_offset;   // Screen rows, negative moves up
        logic [`ADDR_W-1:0]       base_addr;  // First pixel of the cel in ROM
    } sprite_desc_t;

    // Index 0 is fighter one, index 1 fighter two
    typedef sprite_desc_t [1:0] sprite_frame_t;

endpackage

/* tb.f */
+incdir+hw
hw/fighter_pkg.sv
hw/sprite_pkg.sv
hw/pose_decode.sv
hw/anim_sequencer.sv
hw/sheet_addresser.sv
hw/descriptor_queue.sv
hw/fighter_frame_top.sv
verification/fighter_frame_tb.sv

/* verification/fighter_frame_tb.sv */
/*
 * Fighter frame testbench
 * Replays the frame vectors, models the renderer credit return and
 * checks every delivered descriptor against the sheet tables
 */
`timescale 1ns/1ns
`include "fighter_defs.svh"

module fighter_frame_tb;
    import fighter_pkg::*;
    import sprite_pkg::*;

    localparam int COLS    = 9;     // Words per vector line
    localparam int LINES   = 32;
    localparam int TIMEOUT = 200;   // Frames

    logic              vsync;
    logic              reset;
    action_req_t [1:0] actions;
    logic              stop;
    logic              credit_return;
    logic              frame_valid;
    sprite_frame_t     frame_out;

    logic [7:0]    vec [COLS*LINES];
    sprite_frame_t exp_q [$];
    pose_t         prev_pose [2];
    int            tick [2];
    int            outstanding;     // Frames the renderer holds without a credit back
    int            received;
    int            hold_left;
    int            hold_base;       // Frames received when the current hold began
    int            hold_want;
    logic [15:0]   lfsr;

    fighter_frame_top uut (
        .vsync         (vsync),
        .reset         (reset),
        .actions       (actions),
        .stop          (stop),
        .credit_return (credit_return),
        .frame_valid   (frame_valid),
        .frame_out     (frame_out)
    );

    always #10 vsync = ~vsync;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic logic next_rand_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        return b;
    endfunction

    // Tick rule per fighter that returns the cel of the new tick
    function automatic int advance(input int f, input pose_t p);
        int cels;
        case (p)
            POSE_STAND: cels = 6;
            POSE_KICK:  cels = 5;
            POSE_SQUAT: cels = 1;
            default:    cels = 4;
        endcase
        if (p != prev_pose[f])
            tick[f] = 0;
        else if (tick[f] >= cels * `TICKS_PER_CEL - 1)
            tick[f] = 0;
        else
            tick[f]++;
        prev_pose[f] = p;
        return tick[f] / `TICKS_PER_CEL;
    endfunction

    function automatic sprite_desc_t expect_desc(input int f, input pose_t p, input int cel);
        sprite_desc_t d;
        sheet_dim_t   sz;
        case (p)   // Width then height with fighter two first
            POSE_FORWARD: sz = f ? {10'd80, 10'd128}  : {10'd96, 10'd112};
            POSE_BACK:    sz = f ? {10'd80, 10'd128}  : {10'd80, 10'd112};
            POSE_KICK:    sz = f ? {10'd112, 10'd128} : {10'd102, 10'd112};
            POSE_PUNCH:   sz = f ? {10'd96, 10'd112}  : {10'd128, 10'd96};
            POSE_SQUAT:   sz = f ? {10'd64, 10'd80}   : {10'd80, 10'd64};
            default:      sz = {10'd80, 10'd112};
        endcase
        d.pose      = p;
        d.cel       = `CEL_W'(cel);
        d.width     = sz.width;
        d.height    = sz.height;
        d.y_offset  = (`DIM_W+1)'((`STAND_H - int'(sz.height)) * 2);
        d.base_addr = `ADDR_W'(cel * int'(sz.width) * int'(sz.height));
        return d;
    endfunction

    task automatic check_desc(input string name, input sprite_desc_t got,
                              input sprite_desc_t want);
        if (got !== want)
            abort_run($sformatf("error %s: got %h expected %h", name, got, want));
    endtask

    task automatic check_valid_count(input string name, input int got, input int want);
        if (got != want)
            abort_run($sformatf("error %s: got %h expected %h", name, got, want));
    endtask

    // --------------------------------------------------
    // One frame of the renderer model
    // --------------------------------------------------
    task automatic next_frame();
        sprite_frame_t want;
        @(negedge vsync);
        if (frame_valid) begin
            if (exp_q.size() == 0)
                abort_run("a frame was delivered when none was expected");
            want = exp_q.pop_front();
            check_desc("frame_out[0]", frame_out[0], want[0]);
            check_desc("frame_out[1]", frame_out[1], want[1]);
            received++;
            outstanding++;
            if (outstanding > `CREDIT_MAX)
                abort_run("the renderer got more frames than it has buffers");
        end
        credit_return = 1'b0;
        if (hold_left > 0) begin
            hold_left--;
            if (hold_left == 0)
                check_valid_count("frames during credit hold", received - hold_base,
                                  hold_want);
        end else if (outstanding > 0 && !(next_rand_bit() & next_rand_bit())) begin
            credit_return = 1'b1;
            outstanding--;
        end
    endtask

    initial begin
        int            base;
        int            count;
        int            waited;
        int            cel;
        pose_t         p;
        sprite_frame_t frm;

        vsync         = 1'b0;
        reset         = 1'b1;
        actions       = '0;
        stop          = 1'b0;
        credit_return = 1'b0;
        lfsr          = 16'd57287;
        outstanding   = 0;
        received      = 0;
        hold_left     = 0;
        hold_base     = 0;
        hold_want     = 0;
        $readmemh("verification/fighter_vectors.txt", vec);

        repeat (3) begin
            @(negedge vsync);
            if (frame_valid)
                abort_run("frame_valid went high during reset");
        end
        reset = 1'b0;

        // Two stages of reset contents and the first sequencer step on stand
        for (int f = 0; f < 2; f++) begin
            prev_pose[f] = POSE_STAND;
            tick[f]      = 0;
            frm[f]       = expect_desc(f, POSE_STAND, 0);
        end
        exp_q.push_back(frm);
        exp_q.push_back(frm);
        for (int f = 0; f < 2; f++)
            frm[f] = expect_desc(f, POSE_STAND, advance(f, POSE_STAND));
        exp_q.push_back(frm);

        for (int ln = 0; ln < LINES && vec[ln*COLS] != 8'h00; ln++) begin
            base      = ln * COLS;
            count     = vec[base];
            hold_left = vec[base + 4];
            hold_base = received;
            hold_want = `CREDIT_MAX - outstanding;   // Buffers still free as the hold begins
            for (int r = 0; r < count; r++) begin
                actions[0] = action_req_t'(vec[base + 1][5:0]);
                actions[1] = action_req_t'(vec[base + 2][5:0]);
                stop       = vec[base + 3][0];
                waited     = 0;
                while (uut.stall) begin       // Held until stage one takes it
                    next_frame();
                    waited++;
                    if (waited > TIMEOUT)
                        abort_run("timeout, the pipeline stayed stalled");
                end
                for (int f = 0; f < 2; f++) begin
                    p   = pose_t'(vec[base + 5 + 2*f][2:0]);
                    cel = advance(f, p);
                    if (r == count - 1)
                        cel = vec[base + 6 + 2*f];   // Cel reached at the end of the run
                    frm[f] = expect_desc(f, p, cel);
                end
                exp_q.push_back(frm);
                next_frame();
            end
        end

        waited = 0;
        while (exp_q.size() > 0) begin
            next_frame();
            waited++;
            if (waited > TIMEOUT)
                abort_run("timeout, frames never reached the renderer");
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* verification/fighter_vectors.txt */
// count act0 act1 stop credit_hold pose0 cel0 pose1 cel1, all hex
// Cels are the ones reached on the last frame of each run, a zero count ends the list
03 00 01 0 00  0 0 0 0
01 22 18 0 00  1 0 2 0
01 0e 0c 0 00  3 0 4 0
01 05 3f 0 00  5 0 1 0
01 3f 3f 1 00  0 0 0 0
2d 20 04 0 00  1 2 5 0
0a 21 02 0 00  1 3 3 1
14 20 02 0 0c  1 2 3 4
04 10 08 0 00  2 0 4 0
04 10 0a 0 00  2 1 3 0
1e 08 00 0 08  4 0 0 4
08 20 10 1 00  0 1 0 5
06 00 00 0 00  0 1 0 0
05 02 04 0 05  3 0 5 0
03 01 20 0 00  0 0 1 0
00 00 00 0 00  0 0 0 0
